//--- hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and address widths
`define WORD_W     16
`define PADDR_W    10
`define PAGE_W     6   // 64 words per page

`define NUM_REGS   8
`define SLICE_LEN  4   // instructions per time slice

// context block word offsets
`define CTX_NEXT   0   // link to next process
`define CTX_PC     1
`define CTX_REGS   2   // eight saved registers
`define CTX_PTAB   10  // page table, one word per logical page

`define NUM_LPAGES 8

`endif

//--- hdl/mem_pkg.sv
`include "cpu_cfg.svh"

package mem_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`PADDR_W-1:0] paddr_t;

  // only page and offset bits are looked at
  typedef logic [`WORD_W-1:0] laddr_t;

  typedef logic [`PADDR_W-`PAGE_W-1:0] ppage_t;
  typedef logic [$clog2(`NUM_LPAGES)-1:0] lpage_t;

  typedef struct packed {
    logic   rd;
    logic   wr;
    paddr_t addr;
    word_t  wdata;
  } mem_req_t;

endpackage

//--- hdl/isa_pkg.sv
`include "cpu_cfg.svh"

package isa_pkg;

  typedef enum logic [7:0] {
    op_jmp     = 8'd1,
    op_ram2reg = 8'd2,
    op_reg2ram = 8'd3,
    op_num2reg = 8'd4,
    op_plus    = 8'd5,
    op_minus   = 8'd6
  } opcode_e;

  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  // first word of an instruction, second word is the operand
  typedef struct packed {
    opcode_e    op;
    logic [7:0] reg_byte;  // register number in low bits
  } inst_hdr_t;

endpackage

//--- hdl/slice_timer.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module slice_timer (
  input  logic                         clka,
  input  logic                         rst,
  input  logic                         inst_retired,
  input  logic                         slice_clr,
  input  logic                         ctx_step,
  output logic                         slice_end,
  output logic [$clog2(`CTX_PTAB)-1:0] ctx_idx,
  output logic                         ctx_last
);

  localparam int IW = $clog2(`CTX_PTAB);
  localparam logic [IW-1:0] IDX_FIRST = IW'(`CTX_PC);
  localparam logic [IW-1:0] IDX_LAST  = IW'(`CTX_REGS + `NUM_REGS - 1);

  logic [$clog2(`SLICE_LEN+1)-1:0] count;

  assign slice_end = count == `SLICE_LEN;
  assign ctx_last  = ctx_idx == IDX_LAST;

  always_ff @(posedge clka) begin
    if (!rst) begin
      count   <= '0;
      ctx_idx <= IDX_FIRST;
    end else begin
      if (slice_clr) count <= '0;
      else if (inst_retired && !slice_end) count <= count + 1'b1;  // hold at limit
      if (ctx_step) ctx_idx <= ctx_last ? IDX_FIRST : ctx_idx + 1'b1;  // pc, then regs
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file
  import mem_pkg::*, isa_pkg::*;
(
  input  logic     clka,
  input  logic     reg_we,
  input  reg_idx_t reg_idx,
  input  word_t    reg_wdata,
  input  reg_idx_t reg_raddr,
  input  logic     pc_we,
  input  laddr_t   pc_next,
  input  logic     pc_inc,
  output word_t    reg_rdata,
  output laddr_t   pc
);

  word_t regs [`NUM_REGS];  // filled by the context restore

  assign reg_rdata = regs[reg_raddr];  // async read

  always_ff @(posedge clka) begin
    if (reg_we) regs[reg_idx] <= reg_wdata;
  end

  always_ff @(posedge clka) begin
    if (pc_we) pc <= pc_next;  // jump or restore
    else if (pc_inc) pc <= pc + 1'b1;
  end

endmodule

//--- hdl/page_mmu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module page_mmu
  import mem_pkg::*;
(
  input  logic   clka,
  input  logic   rst,
  input  logic   xlate_req,
  input  laddr_t xlate_laddr,
  input  paddr_t ctx_base,
  input  logic   flush,
  input  word_t  mem_rdata,
  output logic   xlate_done,
  output paddr_t xlate_paddr,
  output logic   ptab_rd,
  output paddr_t ptab_addr
);

  lpage_t              req_page;
  lpage_t              tag_lpage;   // cached logical page
  ppage_t              tag_ppage;
  lpage_t              miss_lpage;
  logic [`PAGE_W-1:0]  miss_off;
  ppage_t              fill_ppage;
  logic                valid;
  logic                miss_wait;
  logic                hit;

  assign req_page   = xlate_laddr[`PAGE_W +: $bits(lpage_t)];
  assign fill_ppage = mem_rdata[$bits(ppage_t)-1:0];  // page table entry
  assign hit        = valid && tag_lpage == req_page;

  // miss goes straight to the page table of this context
  assign ptab_rd   = xlate_req && !hit;
  assign ptab_addr = ctx_base + paddr_t'(`CTX_PTAB) + paddr_t'(req_page);

  always_ff @(posedge clka) begin
    if (!rst) begin
      valid      <= 1'b0;
      miss_wait  <= 1'b0;
      xlate_done <= 1'b0;
    end else begin
      xlate_done <= (xlate_req && hit) || miss_wait;
      miss_wait  <= ptab_rd;
      if (flush) valid <= 1'b0;
      else if (miss_wait) valid <= 1'b1;
    end
  end

  always_ff @(posedge clka) begin
    if (ptab_rd) begin
      miss_lpage <= req_page;
      miss_off   <= xlate_laddr[`PAGE_W-1:0];
    end
    if (miss_wait) begin
      tag_lpage   <= miss_lpage;
      tag_ppage   <= fill_ppage;
      xlate_paddr <= {fill_ppage, miss_off};
    end else if (xlate_req) begin
      xlate_paddr <= {tag_ppage, xlate_laddr[`PAGE_W-1:0]};  // hit path
    end
  end

endmodule

//--- hdl/cpu_sequencer.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_sequencer
  import mem_pkg::*, isa_pkg::*;
(
  input  logic                         clka,
  input  logic                         rst,
  output mem_req_t                     mem_req,
  input  word_t                        mem_rdata,
  output logic                         xlate_req,
  output laddr_t                       xlate_laddr,
  input  logic                         xlate_done,
  input  paddr_t                       xlate_paddr,
  input  logic                         ptab_rd,
  input  paddr_t                       ptab_addr,
  output paddr_t                       ctx_base,
  output logic                         flush,
  output logic                         inst_retired,
  output logic                         slice_clr,
  input  logic                         slice_end,
  output logic                         ctx_step,
  input  logic [$clog2(`CTX_PTAB)-1:0] ctx_idx,
  input  logic                         ctx_last,
  output logic                         reg_we,
  output reg_idx_t                     reg_idx,
  output word_t                        reg_wdata,
  output reg_idx_t                     reg_raddr,
  input  word_t                        reg_rdata,
  output logic                         pc_we,
  output laddr_t                       pc_next,
  output logic                         pc_inc,
  input  laddr_t                       pc
);

  typedef enum logic [2:0] {
    s_fetch_hdr, s_fetch_opnd, s_exec, s_data_xlate,
    s_data_acc, s_save, s_read_link, s_restore
  } state_e;

  typedef enum logic [1:0] {st_req, st_wait, st_land} step_e;

  state_e                       state;
  step_e                        step;
  inst_hdr_t                    hdr;
  word_t                        opnd;
  logic                         boot;    // first restore keeps base 0
  logic [$clog2(`CTX_PTAB)-1:0] rd_off;  // offset of word in flight
  reg_idx_t                     inst_reg;
  paddr_t                       next_base;
  logic                         is_store;
  logic                         is_mem_op;

  assign inst_reg  = reg_idx_t'(hdr.reg_byte);
  assign next_base = boot ? ctx_base : paddr_t'(mem_rdata);
  assign is_store  = hdr.op == op_reg2ram;
  assign is_mem_op = is_store || hdr.op == op_ram2reg;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= s_read_link;
      step     <= st_wait;  // one idle cycle before the boot restore
      ctx_base <= '0;
      boot     <= 1'b1;
    end else begin
      case (state)
        s_fetch_hdr, s_fetch_opnd: begin
          case (step)
            st_req: begin
              if (state == s_fetch_hdr && slice_end) state <= s_save;
              else step <= st_wait;
            end
            st_wait: if (xlate_done) step <= st_land;
            default: begin
              step  <= st_req;
              state <= (state == s_fetch_hdr) ? s_fetch_opnd : s_exec;
            end
          endcase
        end
        s_exec: state <= is_mem_op ? s_data_xlate : s_fetch_hdr;
        s_data_xlate: begin
          if (step == st_req) begin
            step <= st_wait;
          end else if (xlate_done) begin
            step  <= st_req;
            state <= is_store ? s_fetch_hdr : s_data_acc;
          end
        end
        s_data_acc: state <= s_fetch_hdr;
        s_save: begin
          if (ctx_last) begin
            state <= s_read_link;
            step  <= st_req;
          end
        end
        s_read_link: begin
          case (step)
            st_wait: step <= st_req;
            st_req:  step <= st_land;
            default: begin
              ctx_base <= next_base;  // link word lands here
              boot     <= 1'b0;
              state    <= s_restore;
              step     <= st_req;
            end
          endcase
        end
        s_restore: begin
          if (step == st_land) begin
            state <= s_fetch_hdr;
            step  <= st_req;
          end else if (ctx_last) begin
            step <= st_land;  // drain last register
          end
        end
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == s_fetch_hdr && step == st_land) hdr <= inst_hdr_t'(mem_rdata);
    if (state == s_fetch_opnd && step == st_land) opnd <= mem_rdata;
    rd_off <= ctx_idx;
  end

  always_comb begin
    mem_req      = '0;
    xlate_req    = 1'b0;
    xlate_laddr  = pc;
    flush        = 1'b0;
    inst_retired = 1'b0;
    slice_clr    = 1'b0;
    ctx_step     = 1'b0;
    reg_we       = 1'b0;
    reg_idx      = inst_reg;
    reg_wdata    = opnd;
    reg_raddr    = inst_reg;
    pc_we        = 1'b0;
    pc_next      = opnd;
    pc_inc       = 1'b0;
    case (state)
      s_fetch_hdr, s_fetch_opnd: begin
        case (step)
          st_req: xlate_req = !(state == s_fetch_hdr && slice_end);
          st_wait: begin
            mem_req.rd   = xlate_done;
            mem_req.addr = xlate_paddr;
          end
          default: pc_inc = 1'b1;
        endcase
      end
      s_exec: begin
        case (hdr.op)
          op_jmp:     pc_we = 1'b1;
          op_num2reg: reg_we = 1'b1;
          op_plus: begin
            reg_we    = 1'b1;
            reg_wdata = reg_rdata + opnd;
          end
          op_minus: begin
            reg_we    = 1'b1;
            reg_wdata = reg_rdata - opnd;
          end
          default: reg_we = 1'b0;  // unknown opcodes fall through as no-ops
        endcase
        inst_retired = !is_mem_op;
      end
      s_data_xlate: begin
        xlate_req     = step == st_req;
        xlate_laddr   = opnd;
        mem_req.rd    = xlate_done && !is_store;
        mem_req.wr    = xlate_done && is_store;
        mem_req.addr  = xlate_paddr;
        mem_req.wdata = reg_rdata;
        inst_retired  = xlate_done && is_store;
      end
      s_data_acc: begin
        reg_we       = 1'b1;
        reg_wdata    = mem_rdata;
        inst_retired = 1'b1;
      end
      s_save: begin
        mem_req.wr    = 1'b1;
        mem_req.addr  = ctx_base + paddr_t'(ctx_idx);
        reg_raddr     = reg_idx_t'(ctx_idx - `CTX_REGS);
        mem_req.wdata = (ctx_idx == `CTX_PC) ? pc : reg_rdata;
        ctx_step      = 1'b1;
      end
      s_read_link: begin
        if (step == st_req) begin
          mem_req.rd   = 1'b1;
          mem_req.addr = ctx_base + paddr_t'(`CTX_NEXT);
        end else if (step == st_land) begin
          mem_req.rd   = 1'b1;  // pc of next process already in flight
          mem_req.addr = next_base + paddr_t'(ctx_idx);
          flush        = 1'b1;
          ctx_step     = 1'b1;
        end
      end
      s_restore: begin
        if (step == st_req) begin
          mem_req.rd   = 1'b1;
          mem_req.addr = ctx_base + paddr_t'(ctx_idx);
          ctx_step     = 1'b1;
        end else begin
          slice_clr = 1'b1;
        end
        reg_idx   = reg_idx_t'(rd_off - `CTX_REGS);
        reg_wdata = mem_rdata;
        pc_next   = mem_rdata;
        pc_we     = rd_off == `CTX_PC;
        reg_we    = rd_off != `CTX_PC;
      end
    endcase
    // page table miss borrows the port
    if (ptab_rd) begin
      mem_req.rd   = 1'b1;
      mem_req.addr = ptab_addr;
    end
  end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_top
  import mem_pkg::*, isa_pkg::*;
(
  input  logic     clka,
  input  logic     rst,
  output mem_req_t mem_req,
  input  word_t    mem_rdata
);

  logic                         xlate_req;
  laddr_t                       xlate_laddr;
  logic                         xlate_done;
  paddr_t                       xlate_paddr;
  logic                         ptab_rd;
  paddr_t                       ptab_addr;
  paddr_t                       ctx_base;
  logic                         flush;
  logic                         inst_retired;
  logic                         slice_clr;
  logic                         slice_end;
  logic                         ctx_step;
  logic [$clog2(`CTX_PTAB)-1:0] ctx_idx;
  logic                         ctx_last;
  logic                         reg_we;
  reg_idx_t                     reg_idx;
  word_t                        reg_wdata;
  reg_idx_t                     reg_raddr;
  word_t                        reg_rdata;
  logic                         pc_we;
  laddr_t                       pc_next;
  logic                         pc_inc;
  laddr_t                       pc;

  cpu_sequencer u_seq (
    .clka(clka), .rst(rst), .mem_req(mem_req), .mem_rdata(mem_rdata),
    .xlate_req(xlate_req), .xlate_laddr(xlate_laddr), .xlate_done(xlate_done),
    .xlate_paddr(xlate_paddr), .ptab_rd(ptab_rd), .ptab_addr(ptab_addr),
    .ctx_base(ctx_base), .flush(flush), .inst_retired(inst_retired),
    .slice_clr(slice_clr), .slice_end(slice_end), .ctx_step(ctx_step),
    .ctx_idx(ctx_idx), .ctx_last(ctx_last), .reg_we(reg_we), .reg_idx(reg_idx),
    .reg_wdata(reg_wdata), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
    .pc_we(pc_we), .pc_next(pc_next), .pc_inc(pc_inc), .pc(pc)
  );

  slice_timer u_timer (
    .clka(clka), .rst(rst), .inst_retired(inst_retired), .slice_clr(slice_clr),
    .ctx_step(ctx_step), .slice_end(slice_end), .ctx_idx(ctx_idx), .ctx_last(ctx_last)
  );

  reg_file u_regs (
    .clka(clka), .reg_we(reg_we), .reg_idx(reg_idx), .reg_wdata(reg_wdata),
    .reg_raddr(reg_raddr), .pc_we(pc_we), .pc_next(pc_next), .pc_inc(pc_inc),
    .reg_rdata(reg_rdata), .pc(pc)
  );

  page_mmu u_mmu (
    .clka(clka), .rst(rst), .xlate_req(xlate_req), .xlate_laddr(xlate_laddr),
    .ctx_base(ctx_base), .flush(flush), .mem_rdata(mem_rdata),
    .xlate_done(xlate_done), .xlate_paddr(xlate_paddr),
    .ptab_rd(ptab_rd), .ptab_addr(ptab_addr)
  );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 4  // ns
) (
  output logic clka
);

  initial clka = 1'b0;

  always #(PERIOD / 2) clka = ~clka;

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu
  import mem_pkg::*, isa_pkg::*;
();

  localparam int NUM_SLICES = 6;   // three slices per process
  localparam int NUM_INST   = 16;  // program length, longer than three slices
  localparam int MEM_WORDS  = 1 << `PADDR_W;

  logic     clka;
  logic     rst;
  mem_req_t mem_req;
  word_t    mem_rdata = '0;

  word_t    mem [MEM_WORDS];
  word_t    init_mem [MEM_WORDS];
  word_t    model_mem [MEM_WORDS];
  integer   seed;
  ppage_t   ptab [2][`NUM_LPAGES];
  paddr_t   ctx_base [2];
  laddr_t   m_pc [2];
  word_t    m_regs [2][`NUM_REGS];
  paddr_t   exp_addr [$];
  word_t    exp_data [$];
  int       slice_last [NUM_SLICES];
  int       exp_count;
  int       got;
  int       errors;
  int       slice_errs;
  int       cur_slice;
  int       tests_pass;
  int       tests_fail;
  logic     model_ready;

  tb_clock clk_gen (.clka(clka));

  cpu_top uut (
    .clka(clka), .rst(rst), .mem_req(mem_req), .mem_rdata(mem_rdata)
  );

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // page table entry joined with the page offset
  function automatic paddr_t phys(int p, laddr_t la);
    return {ptab[p][la[`PAGE_W +: $bits(lpage_t)]], la[`PAGE_W-1:0]};
  endfunction

  function automatic string slice_name(int s);
    return $sformatf("slice%0d_proc%s", s, (s % 2 == 0) ? "A" : "B");
  endfunction

  task automatic expect_write(paddr_t addr, word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic build_images();
    int        a;
    int        p;
    int        i;
    int        k;
    int        pick;
    int        tmp;
    int        perm [14];
    inst_hdr_t hdr;
    word_t     opnd;
    opcode_e   last_op;
    reg_idx_t  last_reg;
    for (a = 0; a < MEM_WORDS; a++) begin
      model_mem[a] = word_t'(a * 32'h2c1b) ^ 16'ha5c3;  // distinct word per address
    end
    for (i = 0; i < 14; i++) perm[i] = i + 2;
    for (i = 13; i > 0; i--) begin
      pick       = rand_below(i + 1);
      tmp        = perm[i];
      perm[i]    = perm[pick];
      perm[pick] = tmp;
    end
    // logical pages 6 and 7 map to the same frames in both processes
    for (k = 0; k < `NUM_LPAGES; k++) begin
      ptab[0][k] = ppage_t'(perm[k]);
      ptab[1][k] = ppage_t'((k < 6) ? perm[k + 8] : perm[k]);
    end
    ctx_base[0] = paddr_t'(0);
    ctx_base[1] = paddr_t'(32);
    for (p = 0; p < 2; p++) begin
      model_mem[ctx_base[p] + `CTX_NEXT] = word_t'(ctx_base[1 - p]);  // ring of two
      model_mem[ctx_base[p] + `CTX_PC]   = '0;
      m_pc[p] = '0;
      for (k = 0; k < `NUM_REGS; k++) begin
        m_regs[p][k] = word_t'($random(seed));
        model_mem[ctx_base[p] + `CTX_REGS + k] = m_regs[p][k];
      end
      for (k = 0; k < `NUM_LPAGES; k++) begin
        model_mem[ctx_base[p] + `CTX_PTAB + k] = {12'(rand_below(4096)), ptab[p][k]};
      end
      last_op  = op_jmp;
      last_reg = '0;
      for (i = 0; i < NUM_INST; i++) begin
        hdr.op       = opcode_e'(8'(1 + rand_below(6)));
        hdr.reg_byte = 8'(rand_below(256));
        if (last_op == op_ram2reg && rand_below(2) == 1) begin
          hdr.op            = op_reg2ram;  // copy the loaded word back out
          hdr.reg_byte[2:0] = last_reg;
        end
        case (hdr.op)
          op_jmp: opnd = {7'(rand_below(128)), 9'(2 * i + 2)};  // next instruction, high bits set
          op_ram2reg, op_reg2ram: begin
            opnd = {7'(rand_below(128)), 3'(1 + rand_below(7)), 6'(rand_below(64))};
          end
          default: opnd = word_t'($random(seed));
        endcase
        model_mem[phys(p, laddr_t'(2 * i))]     = word_t'(hdr);
        model_mem[phys(p, laddr_t'(2 * i + 1))] = opnd;
        last_op  = hdr.op;
        last_reg = reg_idx_t'(hdr.reg_byte);
      end
    end
  endtask

  task automatic model_inst(int p);
    inst_hdr_t hdr;
    word_t     opnd;
    reg_idx_t  r;
    paddr_t    pa;
    hdr     = inst_hdr_t'(model_mem[phys(p, m_pc[p])]);
    opnd    = model_mem[phys(p, m_pc[p] + 16'd1)];
    m_pc[p] = m_pc[p] + 16'd2;
    r       = reg_idx_t'(hdr.reg_byte);
    pa      = phys(p, opnd);
    case (hdr.op)
      op_jmp:     m_pc[p] = opnd;
      op_num2reg: m_regs[p][r] = opnd;
      op_plus:    m_regs[p][r] = m_regs[p][r] + opnd;
      op_minus:   m_regs[p][r] = m_regs[p][r] - opnd;
      op_ram2reg: m_regs[p][r] = model_mem[pa];
      op_reg2ram: begin
        model_mem[pa] = m_regs[p][r];
        expect_write(pa, m_regs[p][r]);
      end
      default: m_pc[p] = m_pc[p];  // no-op
    endcase
  endtask

  task automatic run_model();
    int s;
    int k;
    int p;
    for (s = 0; s < NUM_SLICES; s++) begin
      p = s % 2;
      for (k = 0; k < `SLICE_LEN; k++) model_inst(p);
      expect_write(ctx_base[p] + paddr_t'(`CTX_PC), m_pc[p]);  // context save
      for (k = 0; k < `NUM_REGS; k++) begin
        expect_write(ctx_base[p] + paddr_t'(`CTX_REGS + k), m_regs[p][k]);
      end
      slice_last[s] = exp_addr.size() - 1;
    end
    exp_count = exp_addr.size();
  endtask

  task automatic check_write();
    if (mem_req.addr != exp_addr[got] || mem_req.wdata != exp_data[got]) begin
      $display("[FAIL] %s write %0d: expected %03h=%04h, actual %03h=%04h",
               slice_name(cur_slice), got, exp_addr[got], exp_data[got],
               mem_req.addr, mem_req.wdata);
      errors++;
      slice_errs++;
    end
    got++;
    if (got == slice_last[cur_slice] + 1) begin
      if (slice_errs == 0) begin
        tests_pass++;
        $display("done %s: ok", slice_name(cur_slice));
      end else begin
        tests_fail++;
        $display("done %s: %0d errors", slice_name(cur_slice), slice_errs);
      end
      slice_errs = 0;
      cur_slice++;
    end
  endtask

  // one cycle read latency, write at the edge
  always @(posedge clka) begin
    if (!rst) begin
      mem <= init_mem;
    end else begin
      if (mem_req.rd) mem_rdata <= mem[mem_req.addr];
      if (mem_req.wr) mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  always @(negedge clka) begin
    if (rst) begin
      if (mem_req.rd && mem_req.wr) begin
        $display("read and write strobes were both high at %0t", $time);
        errors++;
        slice_errs++;
      end
      if (mem_req.wr && got < exp_count) check_write();
    end
  end

  initial begin
    wait (model_ready);
    #(exp_count * 40 * 4);
    $display("timeout, only %0d of %0d writes were seen", got, exp_count);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed        = 32'h4d27;
    rst         = 1'b0;
    got         = 0;
    errors      = 0;
    slice_errs  = 0;
    cur_slice   = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    model_ready = 1'b0;
    build_images();
    init_mem    = model_mem;
    run_model();
    model_ready = 1'b1;
    repeat (4) @(negedge clka);
    rst = 1'b1;
    wait (got == exp_count);
    repeat (2) @(negedge clka);
    $display("tests %0d passed, %0d failed, %0d writes checked, %0d errors",
             tests_pass, tests_fail, got, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/isa_pkg.sv
hdl/slice_timer.sv
hdl/reg_file.sv
hdl/page_mmu.sv
hdl/cpu_sequencer.sv
hdl/cpu_top.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

//--- Makefile
# Verilator build and run of the core testbench

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, nonzero status on failure"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --top-module tb_cpu -f sources.f -o tb_cpu
	./obj_dir/tb_cpu | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "run FAILED"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "no pass line in log"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
